// File: cp0Top.f
+incdir+verilog
verilog/cp0Pkg.sv
verilog/excUnit.sv
verilog/tlbArray.sv
verilog/cp0Regs.sv
verilog/cp0Top.sv
verif/cp0Top_props.sv
verif/cp0Tb.sv

// File: verif/cp0Tb.sv
`timescale 1ns/1ps
`include "cp0_defs.svh"

module cp0Tb;

    import cp0Pkg::*;

    localparam int maxCycles = 3000;    // About ten times what the tests need
    localparam logic [7:0] regList [9] = '{`CP0_INDEX, `CP0_ENTRYLO0, `CP0_ENTRYLO1,
        `CP0_ENTRYHI, `CP0_COUNT, `CP0_COMPARE, `CP0_STATUS, `CP0_CAUSE, `CP0_EPC};
    localparam excCode_e codeList [9] = '{Mod, TLBL, TLBS, AdEL, AdES, Sys, Bp, RI, Ov};

    logic        clk;
    logic        rst;
    logic [5:0]  interrupt;
    logic [7:0]  rAddr;
    logic [31:0] rData;
    logic        wEn;
    logic [7:0]  wAddr;
    logic [31:0] wData;
    logic        excValid;
    excCode_e    excCode;
    logic        excBd;
    logic [31:0] excPc;
    logic [31:0] excBadVAddr;
    logic        eret;
    logic        tlbp;
    logic        tlbr;
    logic        tlbwi;
    logic [31:0] lookupVaddr;
    logic        hasInt;
    logic        redirect;
    logic [31:0] redirectPc;
    logic        lookupHit;
    logic [31:0] lookupPaddr;

    logic [31:0] shadow [9];    // Expected readback of each register in regList
    logic [18:0] vpnTab [4];
    logic [25:0] lo0Tab [4];
    logic [25:0] lo1Tab [4];

    cp0Top UUT (.*);

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp)
            else stopRun($sformatf("error: %0t %s is %h, expected %h", $time, what, got, exp));
    endtask

    function automatic logic [31:0] readMask(input logic [7:0] addr);
        case (addr)
            `CP0_INDEX:                   return 32'h0000_000F;
            `CP0_ENTRYLO0, `CP0_ENTRYLO1: return 32'h03FF_FFFF;
            `CP0_ENTRYHI:                 return 32'hFFFF_E0FF;    // VPN2 and ASID
            `CP0_STATUS:                  return 32'h0000_FF03;
            `CP0_CAUSE:                   return 32'h0000_0300;
            default:                      return 32'hFFFF_FFFF;
        endcase
    endfunction

    task automatic writeReg(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        wEn   <= 1'b1;
        wAddr <= addr;
        wData <= data;
        @(posedge clk);
        wEn <= 1'b0;
    endtask

    task automatic checkReg(input logic [7:0] addr, input logic [31:0] mask, input logic [31:0] exp);
        @(posedge clk);
        rAddr <= addr;
        @(negedge clk);
        checkValue(rData & mask, exp & mask, $sformatf("register %h", addr));
    endtask

    // Bits are {tlbwi, tlbp, tlbr}
    task automatic strobeTlb(input logic [2:0] sel);
        @(posedge clk);
        {tlbwi, tlbp, tlbr} <= sel;
        @(posedge clk);
        {tlbwi, tlbp, tlbr} <= 3'b000;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (maxCycles) @(posedge clk);
        stopRun("watchdog expired, the tests ran longer than 3000 cycles");
    end

    always @(negedge clk) begin
        if (UUT.props.failCount != 0) begin
            stopRun("a timing property of cp0Top failed");
        end
    end

    initial begin
        excCode_e    code;
        logic        bd;
        logic        g;
        logic [31:0] data;
        logic [31:0] pc;
        logic [31:0] bad;
        logic [31:0] oldBad;
        logic [31:0] expEpc;
        logic [25:0] page;
        logic [18:0] missVpn;
        logic [11:0] off;
        int          cmp;
        int          waited;
        int          line;

        void'($urandom(32'h9ae9_8885));
        rst         = 1'b1;
        interrupt   = '0;
        rAddr       = '0;
        wEn         = 1'b0;
        wAddr       = '0;
        wData       = '0;
        excValid    = 1'b0;
        excCode     = Int;
        excBd       = 1'b0;
        excPc       = '0;
        excBadVAddr = '0;
        eret        = 1'b0;
        tlbp        = 1'b0;
        tlbr        = 1'b0;
        tlbwi       = 1'b0;
        lookupVaddr = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        for (int k = 0; k < 9; k++) begin
            data = $urandom;
            if (regList[k] == `CP0_STATUS) begin
                data[0] = 1'b0;    // IE stays off until the interrupt tests
            end
            shadow[k] = data & readMask(regList[k]);
            if (regList[k] == `CP0_STATUS) begin
                shadow[k] = shadow[k] | 32'h0040_0000;    // BEV reads as 1
            end
            writeReg(regList[k], data);
            checkReg(regList[k], '1, shadow[k]);
        end
        for (int k = 0; k < 9; k++) begin
            if (regList[k] != `CP0_COUNT) begin
                checkReg(regList[k], '1, shadow[k]);
            end
        end
        checkReg(8'h08, '1, 32'd0);
        checkReg(8'h78, '1, 32'd0);
        checkReg(8'hF8, '1, 32'd0);

        for (int n = 0; n < 10; n++) begin
            code = codeList[$urandom_range(8)];
            bd   = 1'($urandom_range(1));
            pc   = $urandom & 32'hFFFF_FFFC;
            bad  = $urandom;
            writeReg(`CP0_STATUS, 32'h0);    // Each exception starts with EXL clear
            @(posedge clk);
            rAddr <= `CP0_BADVADDR;
            @(negedge clk);
            oldBad = rData;
            @(posedge clk);
            excValid    <= 1'b1;
            excCode     <= code;
            excBd       <= bd;
            excPc       <= pc;
            excBadVAddr <= bad;
            @(negedge clk);
            checkValue(32'(redirect), 32'd1, "redirect on exception");
            checkValue(redirectPc, `EXC_VECTOR, "redirectPc on exception");
            @(posedge clk);
            excValid <= 1'b0;
            expEpc = bd ? pc - 32'd4 : pc;
            checkReg(`CP0_CAUSE, 32'h8000_007C, {bd, 24'd0, code, 2'd0});
            checkReg(`CP0_EPC, '1, expEpc);
            checkReg(`CP0_STATUS, 32'h2, 32'h2);
            checkReg(`CP0_BADVADDR, '1, (code inside {Mod, TLBL, TLBS, AdEL, AdES}) ? bad : oldBad);
        end

        @(posedge clk);
        eret <= 1'b1;
        @(negedge clk);
        checkValue(32'(redirect), 32'd1, "redirect on eret");
        checkValue(redirectPc, expEpc, "redirectPc on eret");
        @(posedge clk);
        eret <= 1'b0;
        checkReg(`CP0_STATUS, 32'h2, 32'h0);

        writeReg(`CP0_CAUSE, 32'h0000_0100);    // Software IP0
        writeReg(`CP0_STATUS, 32'h0000_0101);
        @(negedge clk);
        checkValue(32'(hasInt), 32'd1, "hasInt from software IP0");
        checkReg(`CP0_STATUS, 32'h2, 32'h2);
        checkValue(32'(hasInt), 32'd0, "hasInt with EXL set");
        checkReg(`CP0_CAUSE, 32'h7C, 32'h0);
        writeReg(`CP0_CAUSE, 32'h0);
        line = $urandom_range(4);
        @(posedge clk);
        interrupt <= 6'(1 << line);
        writeReg(`CP0_STATUS, (32'h0000_0400 << line) | 32'h1);
        @(negedge clk);
        checkValue(32'(hasInt), 32'd1, "hasInt from a hardware line");
        checkReg(`CP0_STATUS, 32'h2, 32'h2);
        checkValue(32'(hasInt), 32'd0, "hasInt with EXL set");
        @(posedge clk);
        interrupt <= '0;
        writeReg(`CP0_STATUS, 32'h0);

        cmp = $urandom_range(10, 3);
        writeReg(`CP0_COMPARE, cmp);
        writeReg(`CP0_COUNT, 32'h0);
        writeReg(`CP0_STATUS, 32'h0000_8001);    // IM7 and IE
        waited = 2;
        @(negedge clk);
        while (hasInt !== 1'b1) begin
            waited++;
            if (waited > 2 * cmp + 3) begin
                stopRun("the timer interrupt did not arrive within 2*Compare+3 cycles");
            end
            @(negedge clk);
        end
        checkReg(`CP0_CAUSE, 32'h4000_0000, 32'h4000_0000);
        writeReg(`CP0_COMPARE, 32'h0);
        checkReg(`CP0_CAUSE, 32'h4000_0000, 32'h0);
        writeReg(`CP0_STATUS, 32'h0);

        for (int i = 0; i < 4; i++) begin
            vpnTab[i] = {15'($urandom), 4'(2 * i + 1)};    // Low bits keep the VPN2s apart
            g         = 1'($urandom_range(1));
            lo0Tab[i] = {20'($urandom), 3'($urandom), 1'($urandom), 1'b1, g};
            lo1Tab[i] = {20'($urandom), 3'($urandom), 1'($urandom), 1'(i), g};
            writeReg(`CP0_INDEX, 32'(2 * i + 1));
            writeReg(`CP0_ENTRYHI, {vpnTab[i], 13'd0});
            writeReg(`CP0_ENTRYLO0, {6'd0, lo0Tab[i]});
            writeReg(`CP0_ENTRYLO1, {6'd0, lo1Tab[i]});
            strobeTlb(3'b100);
        end
        for (int i = 0; i < 4; i++) begin
            writeReg(`CP0_ENTRYHI, {vpnTab[i], 13'd0});
            strobeTlb(3'b010);
            checkReg(`CP0_INDEX, 32'h8000_000F, 32'(2 * i + 1));
            writeReg(`CP0_ENTRYHI, 32'h0);
            writeReg(`CP0_ENTRYLO0, 32'h0);
            writeReg(`CP0_ENTRYLO1, 32'h0);
            strobeTlb(3'b001);    // Index still points at the probed entry
            checkReg(`CP0_ENTRYHI, '1, {vpnTab[i], 13'd0});
            checkReg(`CP0_ENTRYLO0, '1, {6'd0, lo0Tab[i]});
            checkReg(`CP0_ENTRYLO1, '1, {6'd0, lo1Tab[i]});
            for (int p = 0; p < 2; p++) begin
                off  = 12'($urandom);
                page = p ? lo1Tab[i] : lo0Tab[i];
                @(posedge clk);
                lookupVaddr <= {vpnTab[i], 1'(p), off};
                @(negedge clk);
                checkValue(32'(lookupHit), 32'(page[1]), "lookupHit");
                if (page[1]) begin
                    checkValue(lookupPaddr, {page[25:6], off}, "lookupPaddr");
                end
            end
        end
        missVpn = {15'($urandom) | 15'd1, 4'd0};
        writeReg(`CP0_ENTRYHI, {missVpn, 13'd0});
        strobeTlb(3'b010);
        checkReg(`CP0_INDEX, 32'h8000_0000, 32'h8000_0000);
        @(posedge clk);
        lookupVaddr <= {missVpn, 13'($urandom)};
        @(negedge clk);
        checkValue(32'(lookupHit), 32'd0, "lookupHit on a missing page");

        repeat (2) @(posedge clk);
        if (UUT.props.failCount == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            stopRun("a timing property of cp0Top failed");
        end
    end

endmodule

// File: verif/cp0Top_props.sv
`timescale 1ns/1ps
`include "cp0_defs.svh"

module cp0TopProps (
    input logic        clk,
    input logic        rst,
    input logic        hasInt,
    input logic        excValid,
    input logic        excBd,
    input logic [31:0] excPc,
    input logic        eret,
    input logic        exl,
    input logic [31:0] epc,
    input logic        redirect,
    input logic [31:0] redirectPc
);

    int failCount = 0;    // Read by the testbench to end the run

    task automatic recordFailure(input string what);
        failCount++;
        $error("%s", what);
    endtask

    resetQuiet: assert property (@(posedge clk) rst |=> !hasInt && !redirect)
        else recordFailure("hasInt or redirect high right after reset");

    excRedirect: assert property (@(posedge clk) disable iff (rst)
        (hasInt || excValid) |-> redirect && redirectPc == `EXC_VECTOR)
        else recordFailure("exception or interrupt without a redirect to the vector");

    eretRedirect: assert property (@(posedge clk) disable iff (rst)
        (eret && !hasInt && !excValid) |-> redirect && redirectPc == epc)
        else recordFailure("eret did not redirect to EPC");

    quietNoRedirect: assert property (@(posedge clk) disable iff (rst)
        !(hasInt || excValid || eret) |-> !redirect)
        else recordFailure("redirect raised with no event present");

    excSetsExl: assert property (@(posedge clk) disable iff (rst)
        (hasInt || excValid) |=> exl)
        else recordFailure("EXL not set one edge after an exception");

    excEpc: assert property (@(posedge clk) disable iff (rst)
        (excValid && !hasInt) |=> epc == ($past(excBd) ? $past(excPc) - 32'd4 : $past(excPc)))
        else recordFailure("EPC does not hold the restart address");

    eretClearsExl: assert property (@(posedge clk) disable iff (rst)
        (eret && !hasInt && !excValid) |=> !exl)
        else recordFailure("EXL still set one edge after eret");

endmodule

bind cp0Top cp0TopProps props (
    .clk(clk), .rst(rst), .hasInt(hasInt), .excValid(excValid), .excBd(excBd),
    .excPc(excPc), .eret(eret), .exl(exl), .epc(epc), .redirect(redirect),
    .redirectPc(redirectPc)
);

// File: verilog/cp0Top.sv
`timescale 1ns/1ps
`include "cp0_defs.svh"

module cp0Top (
    input  logic             clk,
    input  logic             rst,
    input  logic [5:0]       interrupt,
    input  logic [7:0]       rAddr,
    output logic [31:0]      rData,
    input  logic             wEn,
    input  logic [7:0]       wAddr,
    input  logic [31:0]      wData,
    input  logic             excValid,
    input  cp0Pkg::excCode_e excCode,
    input  logic             excBd,
    input  logic [31:0]      excPc,
    input  logic [31:0]      excBadVAddr,
    input  logic             eret,
    input  logic             tlbp,
    input  logic             tlbr,
    input  logic             tlbwi,
    input  logic [31:0]      lookupVaddr,
    output logic             hasInt,
    output logic             redirect,
    output logic [31:0]      redirectPc,
    output logic             lookupHit,
    output logic [31:0]      lookupPaddr
);

    import cp0Pkg::*;

    logic                  updateEn;
    excCode_e              updCode;
    logic                  updBd;
    logic [31:0]           updEpc;
    logic                  badVAddrEn;
    logic [31:0]           updBadVAddr;
    logic                  clearExl;
    logic                  exl;
    logic [31:0]           epc;
    logic [`TLB_IDX_W-1:0] tlbIndex;
    logic [`TLB_IDX_W-1:0] probeIndex;
    logic                  probeMiss;
    tlbEntry_t             writeEntry;
    tlbEntry_t             readEntry;

    cp0Regs uRegs (
        .clk(clk), .rst(rst), .interrupt(interrupt),
        .rAddr(rAddr), .rData(rData), .wEn(wEn), .wAddr(wAddr), .wData(wData),
        .updateEn(updateEn), .updCode(updCode), .updBd(updBd), .updEpc(updEpc),
        .badVAddrEn(badVAddrEn), .updBadVAddr(updBadVAddr), .clearExl(clearExl),
        .tlbp(tlbp), .tlbr(tlbr), .probeIndex(probeIndex), .probeMiss(probeMiss),
        .readEntry(readEntry), .hasInt(hasInt), .exl(exl), .epc(epc),
        .tlbIndex(tlbIndex), .writeEntry(writeEntry)
    );

    // Probe uses the VPN2 held in EntryHi
    tlbArray uTlb (
        .clk(clk), .rst(rst), .tlbwi(tlbwi), .tlbIndex(tlbIndex),
        .writeEntry(writeEntry), .probeVpn2(writeEntry.vpn2), .lookupVaddr(lookupVaddr),
        .probeIndex(probeIndex), .probeMiss(probeMiss), .readEntry(readEntry),
        .lookupHit(lookupHit), .lookupPaddr(lookupPaddr)
    );

    excUnit uExc (
        .excValid(excValid), .excCode(excCode), .excBd(excBd), .excPc(excPc),
        .excBadVAddr(excBadVAddr), .eret(eret), .hasInt(hasInt), .exl(exl), .epc(epc),
        .updateEn(updateEn), .updCode(updCode), .updBd(updBd), .updEpc(updEpc),
        .badVAddrEn(badVAddrEn), .updBadVAddr(updBadVAddr), .clearExl(clearExl),
        .redirect(redirect), .redirectPc(redirectPc)
    );

endmodule

// File: verilog/cp0Regs.sv
`timescale 1ns/1ps
`include "cp0_defs.svh"

module cp0Regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [5:0]            interrupt,
    input  logic [7:0]            rAddr,
    output logic [31:0]           rData,
    input  logic                  wEn,
    input  logic [7:0]            wAddr,
    input  logic [31:0]           wData,
    input  logic                  updateEn,
    input  cp0Pkg::excCode_e      updCode,
    input  logic                  updBd,
    input  logic [31:0]           updEpc,
    input  logic                  badVAddrEn,
    input  logic [31:0]           updBadVAddr,
    input  logic                  clearExl,
    input  logic                  tlbp,
    input  logic                  tlbr,
    input  logic [`TLB_IDX_W-1:0] probeIndex,
    input  logic                  probeMiss,
    input  cp0Pkg::tlbEntry_t     readEntry,
    output logic                  hasInt,
    output logic                  exl,
    output logic [31:0]           epc,
    output logic [`TLB_IDX_W-1:0] tlbIndex,
    output cp0Pkg::tlbEntry_t     writeEntry
);

    localparam logic [31:0] configVal  = {1'b1, 15'd0, 1'b0, 2'd0, 3'd0, 3'd1, 4'd0, 3'd2};
    localparam logic [31:0] config1Val = {1'b0, 6'(`TLB_ENTRIES - 1), 25'd0};

    logic [31:0] badVAddr;
    logic [32:0] count;        // Architected Count is the upper 32 bits
    logic [31:0] compare;
    logic [7:0]  statusIm;
    logic        statusIe;
    logic        causeBd;
    logic        causeTi;
    logic [7:0]  causeIp;
    logic [4:0]  causeExcCode;
    logic        indexP;
    logic [18:0] entryHiVpn2;
    logic [7:0]  entryHiAsid;
    logic [25:0] entryLo0;
    logic [25:0] entryLo1;
    logic [31:0] statusWord;
    logic [31:0] causeWord;

    assign statusWord = {9'd0, 1'b1, 6'd0, statusIm, 6'd0, exl, statusIe};    // BEV fixed at 1
    assign causeWord  = {causeBd, causeTi, 14'd0, causeIp, 1'b0, causeExcCode, 2'd0};
    assign hasInt     = (|(causeIp & statusIm)) & statusIe & ~exl;

    // The entry's G bit is the AND of both EntryLo G bits
    assign writeEntry = {entryHiVpn2, entryLo0[0] & entryLo1[0], entryLo0[25:1], entryLo1[25:1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            count        <= '0;
            compare      <= '0;
            statusIm     <= '0;
            statusIe     <= 1'b0;
            exl          <= 1'b0;
            causeBd      <= 1'b0;
            causeTi      <= 1'b0;
            causeIp      <= '0;
            causeExcCode <= '0;
            indexP       <= 1'b0;
            tlbIndex     <= '0;
            entryHiVpn2  <= '0;
            entryHiAsid  <= '0;
            entryLo0     <= '0;
            entryLo1     <= '0;
        end else begin
            count        <= count + 33'd1;
            causeIp[7:2] <= {causeTi | interrupt[5], interrupt[4:0]};    // Timer shares IP7
            if (compare != 32'd0 && count[32:1] == compare) begin
                causeTi <= 1'b1;
            end

            if (wEn) begin
                case (wAddr)
                    `CP0_INDEX: begin
                        indexP   <= 1'b0;
                        tlbIndex <= wData[`TLB_IDX_W-1:0];
                    end
                    `CP0_ENTRYLO0: entryLo0 <= wData[25:0];
                    `CP0_ENTRYLO1: entryLo1 <= wData[25:0];
                    `CP0_COUNT:    count    <= {wData, 1'b0};
                    `CP0_ENTRYHI: begin
                        entryHiVpn2 <= wData[31:13];
                        entryHiAsid <= wData[7:0];
                    end
                    `CP0_COMPARE: begin
                        compare <= wData;
                        causeTi <= 1'b0;    // Writing Compare acknowledges the timer
                    end
                    `CP0_STATUS: begin
                        statusIm <= wData[15:8];
                        exl      <= wData[1];
                        statusIe <= wData[0];
                    end
                    `CP0_CAUSE: causeIp[1:0] <= wData[9:8];    // Software interrupts only
                    default: ;
                endcase
            end

            if (tlbp) begin
                indexP   <= probeMiss;
                tlbIndex <= probeIndex;
            end
            if (tlbr) begin
                entryHiVpn2 <= readEntry.vpn2;
                entryLo0    <= {readEntry.even, readEntry.g};
                entryLo1    <= {readEntry.odd, readEntry.g};
            end

            if (clearExl) begin
                exl <= 1'b0;
            end
            if (updateEn) begin    // Placed last so hardware wins over software
                causeExcCode <= updCode;
                causeBd      <= updBd;
                exl          <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (updateEn) begin
            epc <= updEpc;
        end else if (wEn && wAddr == `CP0_EPC) begin
            epc <= wData;
        end
        if (badVAddrEn) begin
            badVAddr <= updBadVAddr;
        end
    end

    always_comb begin
        case (rAddr)
            `CP0_INDEX:    rData = {indexP, {(31 - `TLB_IDX_W){1'b0}}, tlbIndex};
            `CP0_ENTRYLO0: rData = {6'd0, entryLo0};
            `CP0_ENTRYLO1: rData = {6'd0, entryLo1};
            `CP0_BADVADDR: rData = badVAddr;
            `CP0_COUNT:    rData = count[32:1];
            `CP0_ENTRYHI:  rData = {entryHiVpn2, 5'd0, entryHiAsid};
            `CP0_COMPARE:  rData = compare;
            `CP0_STATUS:   rData = statusWord;
            `CP0_CAUSE:    rData = causeWord;
            `CP0_EPC:      rData = epc;
            `CP0_CONFIG:   rData = configVal;
            `CP0_CONFIG1:  rData = config1Val;
            default:       rData = 32'd0;
        endcase
    end

endmodule

// File: verilog/tlbArray.sv
`timescale 1ns/1ps
`include "cp0_defs.svh"

module tlbArray (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  tlbwi,
    input  logic [`TLB_IDX_W-1:0] tlbIndex,
    input  cp0Pkg::tlbEntry_t     writeEntry,
    input  logic [18:0]           probeVpn2,
    input  logic [31:0]           lookupVaddr,
    output logic [`TLB_IDX_W-1:0] probeIndex,
    output logic                  probeMiss,
    output cp0Pkg::tlbEntry_t     readEntry,
    output logic                  lookupHit,
    output logic [31:0]           lookupPaddr
);

    import cp0Pkg::*;

    tlbEntry_t               entries [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:0] probeHits;
    logic [`TLB_ENTRIES-1:0] lookupHits;
    logic [`TLB_IDX_W-1:0]   lookupIdx;
    tlbEntry_t               lookupEntry;
    tlbPage_t                lookupPage;

    // Lowest matching index wins when several entries share a VPN2
    function automatic logic [`TLB_IDX_W-1:0] firstSet(input logic [`TLB_ENTRIES-1:0] hits);
        logic [`TLB_IDX_W-1:0] idx;
        idx = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hits[i]) begin
                idx = i[`TLB_IDX_W-1:0];
            end
        end
        return idx;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                entries[i] <= '0;    // Both pages invalid
            end
        end else if (tlbwi) begin
            entries[tlbIndex] <= writeEntry;
        end
    end

    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            probeHits[i]  = (entries[i].vpn2 == probeVpn2);
            lookupHits[i] = (entries[i].vpn2 == lookupVaddr[31:13]);
        end
    end

    assign probeIndex = firstSet(probeHits);
    assign probeMiss  = ~(|probeHits);
    assign readEntry  = entries[tlbIndex];

    assign lookupIdx   = firstSet(lookupHits);
    assign lookupEntry = entries[lookupIdx];
    assign lookupPage  = lookupVaddr[12] ? lookupEntry.odd : lookupEntry.even;    // Bit 12 selects the page
    assign lookupHit   = (|lookupHits) & lookupPage.v;
    assign lookupPaddr = {lookupPage.pfn, lookupVaddr[11:0]};

endmodule

// File: verilog/excUnit.sv
`timescale 1ns/1ps
`include "cp0_defs.svh"

module excUnit (
    input  logic             excValid,
    input  cp0Pkg::excCode_e excCode,
    input  logic             excBd,
    input  logic [31:0]      excPc,
    input  logic [31:0]      excBadVAddr,
    input  logic             eret,
    input  logic             hasInt,
    input  logic             exl,
    input  logic [31:0]      epc,
    output logic             updateEn,
    output cp0Pkg::excCode_e updCode,
    output logic             updBd,
    output logic [31:0]      updEpc,
    output logic             badVAddrEn,
    output logic [31:0]      updBadVAddr,
    output logic             clearExl,
    output logic             redirect,
    output logic [31:0]      redirectPc
);

    import cp0Pkg::*;

    logic addrCode;

    always_comb begin
        case (excCode)
            Mod, TLBL, TLBS, AdEL, AdES: addrCode = 1'b1;
            default:                     addrCode = 1'b0;
        endcase
    end

    assign updBd       = excBd;
    assign updEpc      = excBd ? excPc - 32'd4 : excPc;    // Delay slot restarts at the branch
    assign updBadVAddr = excBadVAddr;

    always_comb begin
        updateEn   = 1'b0;
        updCode    = excCode;
        badVAddrEn = 1'b0;
        clearExl   = 1'b0;
        redirect   = 1'b0;
        redirectPc = `EXC_VECTOR;
        if (hasInt) begin
            updateEn = 1'b1;
            updCode  = Int;
            redirect = 1'b1;
        end else if (excValid) begin
            updateEn   = 1'b1;
            badVAddrEn = addrCode;
            redirect   = 1'b1;
        end else if (eret) begin
            clearExl   = exl;
            redirect   = 1'b1;
            redirectPc = epc;
        end
    end

endmodule

// File: verilog/cp0Pkg.sv
package cp0Pkg;

    typedef enum logic [4:0] {
        Int  = 5'd0,
        Mod  = 5'd1,
        TLBL = 5'd2,
        TLBS = 5'd3,
        AdEL = 5'd4,
        AdES = 5'd5,
        Sys  = 5'd8,
        Bp   = 5'd9,
        RI   = 5'd10,
        Ov   = 5'd12
    } excCode_e;

    typedef struct packed {
        logic [19:0] pfn;
        logic [2:0]  c;
        logic        d;
        logic        v;
    } tlbPage_t;

    typedef struct packed {
        logic [18:0] vpn2;
        logic        g;
        tlbPage_t    even;
        tlbPage_t    odd;
    } tlbEntry_t;

endpackage

// File: verilog/cp0_defs.svh
`ifndef CP0_DEFS_SVH
`define CP0_DEFS_SVH

// CP0 register addresses as {register, select}
`define CP0_INDEX     8'h00
`define CP0_ENTRYLO0  8'h10
`define CP0_ENTRYLO1  8'h18
`define CP0_BADVADDR  8'h40
`define CP0_COUNT     8'h48
`define CP0_ENTRYHI   8'h50
`define CP0_COMPARE   8'h58
`define CP0_STATUS    8'h60
`define CP0_CAUSE     8'h68
`define CP0_EPC       8'h70
`define CP0_CONFIG    8'h80
`define CP0_CONFIG1   8'h81

// Joint TLB geometry
`define TLB_ENTRIES   16
`define TLB_IDX_W     4

// General exception entry with BEV set
`define EXC_VECTOR    32'hBFC0_0380

`endif
